//--- common/cache_pkg.sv
// Shared widths, message formats and FSM states for the blocking cache
// Word requests must stay inside one 32-bit word; memory len counts bytes, 0 means a full line

package cache_pkg;

  // --------------------
  // Geometry
  // --------------------
  localparam int data_bits     = 32;
  localparam int addr_bits     = 32;
  localparam int line_bits     = 128;
  localparam int num_lines     = 16;
  localparam int idx_bits      = 4;
  localparam int off_bits      = 4;
  localparam int tag_bits      = 24;
  localparam int opq_bits      = 8;
  localparam int len_bits      = 2;
  localparam int len_line_bits = 4;

  // Credits held at reset for the memory request channel
  localparam int mem_credits   = 2;
  // Counter width for both credit counters
  localparam int credit_bits   = 3;

  // --------------------
  // Messages
  // --------------------
  typedef enum logic {
    msg_read  = 1'b0,
    msg_write = 1'b1
  } msg_type_e;

  typedef struct packed {
    msg_type_e             type_;
    logic [opq_bits-1:0]   opaque;
    logic [addr_bits-1:0]  addr;
    logic [len_bits-1:0]   len;   // 0 is a full word
    logic [data_bits-1:0]  data;  // Low bytes hold the payload
  } cache_req_t;

  typedef struct packed {
    msg_type_e             type_;
    logic [opq_bits-1:0]   opaque;
    logic [len_bits-1:0]   len;
    logic [data_bits-1:0]  data;
  } cache_resp_t;

  typedef struct packed {
    msg_type_e               type_;
    logic [opq_bits-1:0]     opaque;
    logic [addr_bits-1:0]    addr;
    logic [len_line_bits-1:0] len;
    logic [line_bits-1:0]    data;
  } mem_req_t;

  typedef struct packed {
    msg_type_e               type_;
    logic [opq_bits-1:0]     opaque;
    logic [len_line_bits-1:0] len;
    logic [line_bits-1:0]    data;
  } mem_resp_t;

  // Request address, flat or split for lookup
  typedef union packed {
    logic [addr_bits-1:0] word;
    struct packed {
      logic [tag_bits-1:0] tag;
      logic [idx_bits-1:0] idx;
      logic [1:0]          word_off;
      logic [1:0]          byte_off;
    } f;
  } cache_addr_u;

  typedef enum logic [2:0] {
    st_idle,
    st_tag_check,
    st_refill_req,
    st_refill_wait,
    st_write_req,
    st_write_wait,
    st_resp
  } cache_state_e;

endpackage

//--- common/cache_ctrl_if.sv
// Control strobes from the cache FSM and status back from the datapath
// memresp_val comes in as a port so the datapath can check its timing

`timescale 1ns/1ps

interface cache_ctrl_if import cache_pkg::*; (
  input logic memresp_val
);

  // Strobes from control
  logic         req_load;
  logic         resp_load_hit;
  logic         resp_load_mem;
  logic         tag_wen;
  logic         data_wen_line;
  logic         data_wen_word;
  logic         memreq_sel_line;
  cache_state_e state;

  // Status from datapath
  msg_type_e    req_type;
  logic         tag_hit;

  modport ctrl (
    output req_load, resp_load_hit, resp_load_mem,
    output tag_wen, data_wen_line, data_wen_word,
    output memreq_sel_line, state,
    input  req_type, tag_hit
  );

  modport dpath (
    input  req_load, resp_load_hit, resp_load_mem,
    input  tag_wen, data_wen_line, data_wen_word,
    input  memreq_sel_line, state, memresp_val,
    output req_type, tag_hit
  );

endinterface

//--- cache/cache_tag_array.sv
// Valid bits and tags for a direct-mapped cache
// Hit is combinational on the addressed line

`timescale 1ns/1ps

module cache_tag_array import cache_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  logic [idx_bits-1:0] index,
  input  logic [tag_bits-1:0] tag,
  input  logic                wen,
  output logic                hit
);

  logic [num_lines-1:0] valid_q;
  logic [tag_bits-1:0]  tag_mem [num_lines];

  // --------------------
  // Valid bits
  // --------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (wen) begin
      valid_q[index] <= 1'b1;
    end
  end

  // Tag storage, refilled lines only
  always_ff @(posedge clk) begin
    if (wen) begin
      tag_mem[index] <= tag;
    end
  end

  // --------------------
  // Lookup
  // --------------------
  // Hit needs both a live line and matching tag
  assign hit = valid_q[index] && (tag_mem[index] == tag);

endmodule

//--- cache/cache_dpath.sv
// Blocking cache datapath: request hold, data array, merge and message formation
// Sub-word accesses must not cross a word; payload data is right-aligned as in memory

`timescale 1ns/1ps

module cache_dpath import cache_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  cache_req_t  cachereq_msg,
  output cache_resp_t cacheresp_msg,
  output mem_req_t    memreq_msg,
  input  mem_resp_t   memresp_msg,
  cache_ctrl_if.dpath dp
);

  cache_req_t           req_q;
  cache_addr_u          addr_q;
  logic [3:0]           len_mask;
  logic [3:0]           byte_mask;
  logic [2:0]           len_bytes;
  logic [data_bits-1:0] wdata_shifted;
  logic [line_bits-1:0] data_mem [num_lines];
  logic [line_bits-1:0] merged_line;
  logic [data_bits-1:0] hit_word;
  logic [data_bits-1:0] mem_word;
  logic [data_bits-1:0] resp_data_q;

  // Word out of a line, shifted down and trimmed to the access size
  function automatic logic [data_bits-1:0] pick_word(
    input logic [line_bits-1:0] line,
    input cache_addr_u          a,
    input logic [3:0]           lmask
  );
    logic [data_bits-1:0] w;
    logic [data_bits-1:0] m;
    w = line[a.f.word_off*data_bits +: data_bits];
    w = w >> {a.f.byte_off, 3'b000};
    m = {{8{lmask[3]}}, {8{lmask[2]}}, {8{lmask[1]}}, {8{lmask[0]}}};
    return w & m;
  endfunction

  // --------------------
  // Request hold
  // --------------------
  always_ff @(posedge clk) begin
    if (dp.req_load) begin
      req_q <= cachereq_msg;
    end
  end

  assign addr_q.word = req_q.addr;
  assign dp.req_type = req_q.type_;

  // Length 0 is a full word
  always_comb begin
    case (req_q.len)
      2'd1:    len_mask = 4'b0001;
      2'd2:    len_mask = 4'b0011;
      2'd3:    len_mask = 4'b0111;
      default: len_mask = 4'b1111;
    endcase
  end

  assign len_bytes     = (req_q.len == '0) ? 3'd4 : {1'b0, req_q.len};
  assign byte_mask     = len_mask << addr_q.f.byte_off;
  assign wdata_shifted = req_q.data << {addr_q.f.byte_off, 3'b000};

  // --------------------
  // Tags and data
  // --------------------
  cache_tag_array tags_i (
    .clk   (clk),
    .rst_n (rst_n),
    .index (addr_q.f.idx),
    .tag   (addr_q.f.tag),
    .wen   (dp.tag_wen),
    .hit   (dp.tag_hit)
  );

  // Write hit, replace only the enabled bytes
  always_comb begin
    merged_line = data_mem[addr_q.f.idx];
    for (int b = 0; b < 4; b++) begin
      if (byte_mask[b]) begin
        merged_line[(int'(addr_q.f.word_off) * 4 + b) * 8 +: 8] = wdata_shifted[b*8 +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (dp.data_wen_line) begin
      data_mem[addr_q.f.idx] <= memresp_msg.data;
    end else if (dp.data_wen_word) begin
      data_mem[addr_q.f.idx] <= merged_line;
    end
  end

  // --------------------
  // Response
  // --------------------
  assign hit_word = pick_word(data_mem[addr_q.f.idx], addr_q, len_mask);
  // Write acks carry no data
  assign mem_word = (req_q.type_ == msg_write) ? '0
                  : pick_word(memresp_msg.data, addr_q, len_mask);

  always_ff @(posedge clk) begin
    if (dp.resp_load_hit) begin
      resp_data_q <= hit_word;
    end else if (dp.resp_load_mem) begin
      resp_data_q <= mem_word;
    end
  end

  assign cacheresp_msg.type_  = req_q.type_;
  assign cacheresp_msg.opaque = req_q.opaque;
  assign cacheresp_msg.len    = req_q.len;
  assign cacheresp_msg.data   = resp_data_q;

  // Memory request, line read on refill else word write-through
  always_comb begin
    memreq_msg.opaque = req_q.opaque;
    if (dp.memreq_sel_line) begin
      memreq_msg.type_ = msg_read;
      memreq_msg.addr  = {req_q.addr[addr_bits-1:off_bits], {off_bits{1'b0}}};
      memreq_msg.len   = '0;
      memreq_msg.data  = '0;
    end else begin
      memreq_msg.type_ = msg_write;
      memreq_msg.addr  = req_q.addr;
      memreq_msg.len   = len_line_bits'(len_bytes);
      memreq_msg.data  = line_bits'(req_q.data);
    end
  end

  // Memory answers only what the FSM is waiting for
  a_memresp_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
    dp.memresp_val |-> (dp.state == st_refill_wait || dp.state == st_write_wait));

endmodule

//--- cache/cache_ctrl.sv
// Blocking cache FSM, one transaction in flight
// Response and memory request channels are credit based; memory responses are not

`timescale 1ns/1ps

module cache_ctrl import cache_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       cachereq_val,
  output logic       cachereq_credit,
  output logic       cacheresp_val,
  input  logic       cacheresp_credit,
  output logic       memreq_val,
  input  logic       memreq_credit,
  input  logic       memresp_val,
  cache_ctrl_if.ctrl ctrl
);

  cache_state_e           state_q;
  cache_state_e           state_d;
  logic [credit_bits-1:0] resp_cnt_q;
  logic [credit_bits-1:0] mem_cnt_q;
  logic                   resp_ok;
  logic                   mem_ok;

  assign resp_ok = (resp_cnt_q != '0);
  assign mem_ok  = (mem_cnt_q != '0);

  // --------------------
  // Channel handshakes
  // --------------------
  assign cacheresp_val   = (state_q == st_resp) && resp_ok;
  // Requester gets its credit back with the response
  assign cachereq_credit = cacheresp_val;
  assign memreq_val      = (state_q == st_refill_req || state_q == st_write_req) && mem_ok;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      resp_cnt_q <= '0;
      mem_cnt_q  <= credit_bits'(mem_credits);
    end else begin
      resp_cnt_q <= resp_cnt_q + credit_bits'(cacheresp_credit)
                  - credit_bits'(cacheresp_val);
      mem_cnt_q  <= mem_cnt_q + credit_bits'(memreq_credit)
                  - credit_bits'(memreq_val);
    end
  end

  // --------------------
  // FSM
  // --------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d              = state_q;
    ctrl.req_load        = 1'b0;
    ctrl.resp_load_hit   = 1'b0;
    ctrl.resp_load_mem   = 1'b0;
    ctrl.tag_wen         = 1'b0;
    ctrl.data_wen_line   = 1'b0;
    ctrl.data_wen_word   = 1'b0;
    ctrl.memreq_sel_line = (state_q == st_refill_req);
    case (state_q)
      st_idle: begin
        if (cachereq_val) begin
          ctrl.req_load = 1'b1;
          state_d       = st_tag_check;
        end
      end
      st_tag_check: begin
        if (ctrl.req_type == msg_write) begin
          // Update on hit, memory always
          ctrl.data_wen_word = ctrl.tag_hit;
          state_d            = st_write_req;
        end else if (ctrl.tag_hit) begin
          ctrl.resp_load_hit = 1'b1;
          state_d            = st_resp;
        end else begin
          state_d = st_refill_req;
        end
      end
      st_refill_req: begin
        if (mem_ok) state_d = st_refill_wait;
      end
      st_refill_wait: begin
        if (memresp_val) begin
          ctrl.data_wen_line = 1'b1;
          ctrl.tag_wen       = 1'b1;
          ctrl.resp_load_mem = 1'b1;
          state_d            = st_resp;
        end
      end
      st_write_req: begin
        if (mem_ok) state_d = st_write_wait;
      end
      st_write_wait: begin
        if (memresp_val) begin
          ctrl.resp_load_mem = 1'b1;
          state_d            = st_resp;
        end
      end
      st_resp: begin
        // Held here until a response credit exists
        if (resp_ok) state_d = st_idle;
      end
      default: state_d = st_idle;
    endcase
  end

  assign ctrl.state = state_q;

  // --------------------
  // Credit checks
  // --------------------
  // Requester never grants more response credits than the counter holds
  a_resp_credit: assert property (@(posedge clk) disable iff (!rst_n)
    (cacheresp_credit && !cacheresp_val) |-> resp_cnt_q != '1);

  // Memory never returns more credits than it was given
  a_mem_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
    mem_cnt_q <= credit_bits'(mem_credits));

endmodule

//--- design/blocking_cache_top.sv
// Blocking direct-mapped write-through cache, 256 bytes in 16 lines
// Requester holds one request credit after reset and grants response credits

`timescale 1ns/1ps

module blocking_cache_top import cache_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,

  // Cache request
  input  logic        cachereq_val,
  input  cache_req_t  cachereq_msg,
  output logic        cachereq_credit,

  // Cache response
  output logic        cacheresp_val,
  output cache_resp_t cacheresp_msg,
  input  logic        cacheresp_credit,

  // Memory request
  output logic        memreq_val,
  output mem_req_t    memreq_msg,
  input  logic        memreq_credit,

  // Memory response, no credits
  input  logic        memresp_val,
  input  mem_resp_t   memresp_msg
);

  cache_ctrl_if ctrl_bus (.memresp_val(memresp_val));

  cache_ctrl ctrl_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .cachereq_val     (cachereq_val),
    .cachereq_credit  (cachereq_credit),
    .cacheresp_val    (cacheresp_val),
    .cacheresp_credit (cacheresp_credit),
    .memreq_val       (memreq_val),
    .memreq_credit    (memreq_credit),
    .memresp_val      (memresp_val),
    .ctrl             (ctrl_bus.ctrl)
  );

  cache_dpath dpath_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .cachereq_msg  (cachereq_msg),
    .cacheresp_msg (cacheresp_msg),
    .memreq_msg    (memreq_msg),
    .memresp_msg   (memresp_msg),
    .dp            (ctrl_bus.dpath)
  );

endmodule

//--- sim/tb_mem_model.sv
// Behavioral 4 KB main memory, one request at a time, addresses wrap at 4 KB
// Line reads return 16 bytes from the aligned address; writes store len bytes

`timescale 1ns/1ps

module tb_mem_model import cache_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 memreq_val,
  input  mem_req_t             memreq_msg,
  output logic                 memreq_credit,
  output logic                 memresp_val,
  output mem_resp_t            memresp_msg,
  output int                   reads_seen,
  output logic [addr_bits-1:0] last_read_addr
);

  localparam int mem_bytes = 4096;

  logic [7:0] mem [mem_bytes];
  mem_req_t   req;
  mem_resp_t  resp;
  int         lat;

  // Fill pattern, high nibble folded in so aliased lines differ
  function automatic logic [7:0] fill_byte(input logic [11:0] a);
    return (a[7:0] + 8'h5a) ^ {4'h0, a[11:8]};
  endfunction

  // Access done at consume time, answer formed right away
  task automatic serve(input mem_req_t rq, output mem_resp_t rs);
    logic [11:0] base;
    int          n;
    base      = rq.addr[11:0];
    n         = (rq.len == '0) ? line_bits / 8 : int'(rq.len);
    rs        = '0;
    rs.type_  = rq.type_;
    rs.opaque = rq.opaque;
    rs.len    = rq.len;
    for (int i = 0; i < n; i++) begin
      if (rq.type_ == msg_write) begin
        mem[12'(base + i)] = rq.data[i*8 +: 8];
      end else begin
        rs.data[i*8 +: 8] = mem[12'(base + i)];
      end
    end
    if (rq.type_ == msg_read) begin
      reads_seen++;
      last_read_addr = rq.addr;
    end
  endtask

  initial begin
    for (int a = 0; a < mem_bytes; a++) begin
      mem[a] = fill_byte(12'(a));
    end
  end

  // --------------------
  // Request service
  // --------------------
  initial begin
    memreq_credit  = 1'b0;
    memresp_val    = 1'b0;
    memresp_msg    = '0;
    reads_seen     = 0;
    last_read_addr = '0;
    forever begin
      @(posedge clk);
      if (rst_n && memreq_val) begin
        req = memreq_msg;
        serve(req, resp);
        lat = $urandom_range(6, 1);
        // Credit back after one cycle, answer after lat cycles
        for (int c = 1; c <= lat; c++) begin
          @(negedge clk);
          memreq_credit = (c == 1);
          memresp_val   = (c == lat);
          if (c == lat) begin
            memresp_msg = resp;
          end
        end
        @(negedge clk);
        memreq_credit = 1'b0;
        memresp_val   = 1'b0;
      end
    end
  end

endmodule

//--- sim/cache_tb.sv
// Testbench for the blocking cache, transactions and expected values from sim/cache_input.txt
// Run from the project root; the file path is relative to it

`timescale 1ns/1ps

module cache_tb import cache_pkg::*; ();

  localparam int rst_cycles      = 16;
  localparam int cycles_per_line = 400;

  logic                 clk;
  logic                 rst_n;
  logic                 cachereq_val;
  cache_req_t           cachereq_msg;
  logic                 cachereq_credit;
  logic                 cacheresp_val;
  cache_resp_t          cacheresp_msg;
  logic                 cacheresp_credit;
  logic                 memreq_val;
  mem_req_t             memreq_msg;
  logic                 memreq_credit;
  logic                 memresp_val;
  mem_resp_t            memresp_msg;
  int                   reads_seen;
  logic [addr_bits-1:0] last_read_addr;

  // Parsed transactions
  logic        rec_write [$];
  logic [31:0] rec_addr  [$];
  logic [1:0]  rec_len   [$];
  logic [31:0] rec_wdata [$];
  logic [31:0] rec_exp   [$];
  logic        rec_read  [$];
  int          rec_line  [$];

  // Scoreboard state
  cache_resp_t resp_fifo [$];
  int          req_credits;
  int          resp_grants;
  int          credit_pulses;
  int          resp_seen;
  int          errors;
  int          num_file_lines;
  bit          loaded;

  blocking_cache_top dut_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .cachereq_val     (cachereq_val),
    .cachereq_msg     (cachereq_msg),
    .cachereq_credit  (cachereq_credit),
    .cacheresp_val    (cacheresp_val),
    .cacheresp_msg    (cacheresp_msg),
    .cacheresp_credit (cacheresp_credit),
    .memreq_val       (memreq_val),
    .memreq_msg       (memreq_msg),
    .memreq_credit    (memreq_credit),
    .memresp_val      (memresp_val),
    .memresp_msg      (memresp_msg)
  );

  tb_mem_model mem_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .memreq_val     (memreq_val),
    .memreq_msg     (memreq_msg),
    .memreq_credit  (memreq_credit),
    .memresp_val    (memresp_val),
    .memresp_msg    (memresp_msg),
    .reads_seen     (reads_seen),
    .last_read_addr (last_read_addr)
  );

  // --------------------
  // Reporting
  // --------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_eq(input logic [127:0] actual, input logic [127:0] expected,
                          input string what);
    if (actual !== expected) begin
      errors++;
      abort_run($sformatf("FAIL at %0t ns: %s (got %0h, expected %0h)",
                          $time, what, actual, expected));
    end
  endtask

  // --------------------
  // Input file
  // --------------------
  // Lines of "# ..." are comments; opaque is the file line number
  task automatic load_input();
    int                  fd;
    int                  code;
    int                  line_no;
    int                  len;
    int                  exp_read;
    logic [63:0]         op_word;
    logic [31:0]         addr;
    logic [31:0]         wdata;
    logic [31:0]         exp_data;
    logic [8*200-1:0]    rest;
    fd = $fopen("sim/cache_input.txt", "r");
    if (fd == 0) begin
      abort_run("Cannot open sim/cache_input.txt, run from the project root");
    end
    line_no = 0;
    code    = $fscanf(fd, "%s", op_word);
    while (code == 1) begin
      line_no++;
      if (op_word == "#") begin
        code = $fgets(rest, fd);
      end else begin
        code = $fscanf(fd, "%h %d %h %h %d", addr, len, wdata, exp_data, exp_read);
        if (code != 5 || (op_word != "R" && op_word != "W")) begin
          abort_run($sformatf("Malformed line %0d in the input file", line_no));
        end
        rec_write.push_back(op_word == "W");
        rec_addr.push_back(addr);
        rec_len.push_back(len[1:0]);
        rec_wdata.push_back(wdata);
        rec_exp.push_back(exp_data);
        rec_read.push_back(exp_read != 0);
        rec_line.push_back(line_no);
      end
      code = $fscanf(fd, "%s", op_word);
    end
    $fclose(fd);
    num_file_lines = line_no;
  endtask

  // --------------------
  // Clock, watchdog, monitor
  // --------------------
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    int limit;
    wait (loaded);
    limit = rst_cycles + cycles_per_line * num_file_lines;
    repeat (limit) @(posedge clk);
    abort_run($sformatf("Timeout: run did not finish within %0d cycles", limit));
  end

  // Credit bookkeeping and response capture
  always @(posedge clk) begin
    if (rst_n) begin
      if (cacheresp_val) begin
        check_eq(resp_grants > 0, 1, "response sent without a granted credit");
        resp_fifo.push_back(cacheresp_msg);
        resp_seen++;
      end
      if (cachereq_credit) begin
        credit_pulses++;
      end
      if (cachereq_val) begin
        req_credits--;
      end
      resp_grants += int'(cacheresp_credit) - int'(cacheresp_val);
      req_credits += int'(cachereq_credit);
      check_eq(req_credits <= 1, 1, "request credit returned twice");
    end
  end

  // --------------------
  // One transaction
  // --------------------
  task automatic run_one(input int t);
    int          reads_before;
    int          gap;
    int          nbytes;
    logic [7:0]  opq;
    msg_type_e   exp_type;
    cache_resp_t rsp;
    string       tag;
    opq          = 8'(rec_line[t]);
    exp_type     = rec_write[t] ? msg_write : msg_read;
    tag          = $sformatf("line %0d", rec_line[t]);
    reads_before = reads_seen;
    while (req_credits == 0) @(negedge clk);
    cachereq_msg.type_  = exp_type;
    cachereq_msg.opaque = opq;
    cachereq_msg.addr   = rec_addr[t];
    cachereq_msg.len    = rec_len[t];
    cachereq_msg.data   = rec_wdata[t];
    cachereq_val        = 1'b1;
    @(negedge clk);
    cachereq_val = 1'b0;
    // Withhold the response credit for a random gap
    gap = $urandom_range(4, 0);
    repeat (gap) @(negedge clk);
    cacheresp_credit = 1'b1;
    @(negedge clk);
    cacheresp_credit = 1'b0;
    while (resp_fifo.size() == 0) @(negedge clk);
    rsp = resp_fifo.pop_front();
    check_eq(rsp.opaque, opq, {tag, " opaque echo"});
    check_eq(rsp.type_, exp_type, {tag, " type echo"});
    check_eq(rsp.len, rec_len[t], {tag, " length echo"});
    if (!rec_write[t]) begin
      check_eq(rsp.data, rec_exp[t], {tag, " read data"});
    end
    check_eq(reads_seen - reads_before, rec_read[t], {tag, " memory line reads"});
    if (rec_read[t]) begin
      check_eq(last_read_addr, {rec_addr[t][31:4], 4'h0}, {tag, " refill address"});
    end
    check_eq(credit_pulses, resp_seen, {tag, " request credits per response"});
    // Write-through leaves the bytes in memory
    if (rec_write[t]) begin
      nbytes = (rec_len[t] == 2'd0) ? 4 : int'(rec_len[t]);
      for (int i = 0; i < nbytes; i++) begin
        check_eq(mem_i.mem[12'(rec_addr[t] + i)], rec_wdata[t][i*8 +: 8],
                 {tag, " memory byte"});
      end
    end
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    rst_n            = 1'b0;
    cachereq_val     = 1'b0;
    cachereq_msg     = '0;
    cacheresp_credit = 1'b0;
    req_credits      = 1;
    resp_grants      = 0;
    credit_pulses    = 0;
    resp_seen        = 0;
    errors           = 0;
    loaded           = 1'b0;
    void'($urandom(32'h1ce5_3b41));
    load_input();
    loaded = 1'b1;
    repeat (rst_cycles) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    for (int t = 0; t < rec_addr.size(); t++) begin
      run_one(t);
    end
    check_eq(resp_seen, rec_addr.size(), "responses against requests");
    if (errors == 0) begin
      $display("Simulation passed");
      $finish;
    end else begin
      $display("Simulation failed");
      $fatal(1);
    end
  end

endmodule

//--- sim/cache_input.txt
# op addr(hex) len wdata(hex) expected_rdata(hex) expect_mem_line_read
# len 0 is a full word; write rows carry rdata 0
R 040 0 00000000 9d9c9b9a 1
R 044 0 00000000 a1a09f9e 0
R 040 0 00000000 9d9c9b9a 0
W 048 0 deadbeef 00000000 0
R 048 0 00000000 deadbeef 0
W 049 1 00000011 00000000 0
R 048 0 00000000 dead11ef 0
W 04a 2 00007766 00000000 0
R 048 0 00000000 776611ef 0
R 04a 2 00000000 00007766 0
R 049 1 00000000 00000011 0
R 04d 3 00000000 00a9a8a7 0
W 084 0 12345678 00000000 0
R 084 0 00000000 12345678 1
R 080 0 00000000 dddcdbda 0
R 1c0 0 00000000 1c1d1a1b 1
R 3c0 0 00000000 1e1f1819 1
R 1c0 0 00000000 1c1d1a1b 1
R 3c0 0 00000000 1e1f1819 1
W 1c4 1 000000a5 00000000 0
R 1c4 0 00000000 20211ea5 1
R 3c0 0 00000000 1e1f1819 1
R 0ff 1 00000000 00000059 1
W 0fc 0 cafef00d 00000000 0
R 0fe 2 00000000 0000cafe 0
R 0fc 0 00000000 cafef00d 0

//--- verilog.f
common/cache_pkg.sv
common/cache_ctrl_if.sv
cache/cache_tag_array.sv
cache/cache_dpath.sv
cache/cache_ctrl.sv
design/blocking_cache_top.sv
sim/tb_mem_model.sv
sim/cache_tb.sv

//--- Bender.yml
package:
  name: blocking_cache

sources:
  # Shared package and interface
  - common/cache_pkg.sv
  - common/cache_ctrl_if.sv
  # Cache blocks
  - cache/cache_tag_array.sv
  - cache/cache_dpath.sv
  - cache/cache_ctrl.sv
  # Top level
  - design/blocking_cache_top.sv
  # Testbench
  - target: simulation
    files:
      - sim/tb_mem_model.sv
      - sim/cache_tb.sv
